// File: common/joybus_pkg.sv
`default_nettype none

package joybus_pkg;

    typedef enum logic [7:0] {
        CMD_EEPROM_STATUS = 8'h00,
        CMD_EEPROM_READ   = 8'h04,
        CMD_EEPROM_WRITE  = 8'h05,
        CMD_RTC_STATUS    = 8'h06,
        CMD_RTC_READ      = 8'h07,
        CMD_RTC_WRITE     = 8'h08
    } cmd_e;

    // Host clock sub-periods per line bit
    localparam int SUB_BITS = 8;
    // Received low pulse shorter than this decodes as 1
    localparam int ONE_LOW_MAX = 3;
    localparam int TX_ONE_LOW = 2;
    localparam int TX_ZERO_LOW = 6;
    // Block address plus sub-address
    localparam int EEPROM_ADDR_W = 11;

    typedef struct packed {
        logic clk_rise;
        logic clk_fall;
        logic dq;
    } si_events_t;

    typedef struct packed {
        logic       valid;
        logic [7:0] data;
        logic       stop;
        logic       timeout;
    } rx_byte_t;

    typedef struct packed {
        logic       byte_req;
        logic       stop_req;
        logic [7:0] data;
    } tx_req_t;

    typedef struct packed {
        logic [6:0] seconds;
        logic [6:0] minutes;
        logic [5:0] hours;
        logic [5:0] day;
        logic [2:0] weekday;
        logic [4:0] month;
        logic [7:0] year;
    } rtc_time_t;

endpackage

`default_nettype wire

// File: joybus/si_line_sync.sv
`default_nettype none

module si_line_sync (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   host_reset,
    input  logic                   host_clk,
    input  logic                   dq_in,
    input  logic                   line_low,
    output joybus_pkg::si_events_t events,
    output logic                   dq_oe
);

    logic [1:0] host_reset_ff;
    logic [1:0] host_clk_ff;
    logic       dq_ff;
    logic       last_clk;
    logic       host_run;
    logic       clk_s;

    always_comb begin
        host_run = host_reset_ff[1];
        clk_s = host_clk_ff[1];
    end

    always_ff @(posedge clk) begin
        host_reset_ff <= {host_reset_ff[0], host_reset};
        host_clk_ff <= {host_clk_ff[0], host_clk};
        dq_ff <= dq_in;
        last_clk <= clk_s;
    end

    // Registered events, no edges while host reset is held low
    always_ff @(posedge clk) begin
        if (reset) begin
            events <= '{clk_rise: 1'b0, clk_fall: 1'b0, dq: 1'b1};
            dq_oe <= 1'b0;
        end else begin
            events.clk_rise <= host_run && !last_clk && clk_s;
            events.clk_fall <= host_run && last_clk && !clk_s;
            events.dq <= dq_ff;
            dq_oe <= line_low;
        end
    end

endmodule

`default_nettype wire

// File: joybus/joybus_rx.sv
`default_nettype none

module joybus_rx (
    input  logic                   clk,
    input  logic                   reset,
    input  joybus_pkg::si_events_t events,
    output joybus_pkg::rx_byte_t   rx
);
    import joybus_pkg::*;

    logic       last_dq;
    logic       dq_fall;
    logic       dq_rise;
    logic       timeout;
    logic [3:0] sub_count;
    logic [2:0] bit_count;
    logic [7:0] shift;
    logic       byte_valid;

    // Line sampled on host clock rises only
    always_comb begin
        dq_fall = events.clk_rise && last_dq && !events.dq;
        dq_rise = events.clk_rise && !last_dq && events.dq;
        timeout = events.clk_rise && events.dq && (&sub_count);
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            last_dq <= 1'b1;
            sub_count <= '1;
        end else begin
            if (events.clk_rise) begin
                last_dq <= events.dq;
            end
            if (dq_fall) begin
                sub_count <= '0;
            end else if (events.clk_rise && !(&sub_count)) begin
                sub_count <= sub_count + 4'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            bit_count <= '0;
            byte_valid <= 1'b0;
        end else begin
            byte_valid <= 1'b0;
            if (timeout) begin
                bit_count <= '0;
            end
            if (dq_rise) begin
                bit_count <= bit_count + 3'd1;
                if (&bit_count) begin
                    byte_valid <= 1'b1;
                end
            end
        end
    end

    // MSB first, short low is a 1
    always_ff @(posedge clk) begin
        if (dq_rise) begin
            shift <= {shift[6:0], (sub_count < ONE_LOW_MAX)};
        end
    end

    always_comb begin
        rx.valid = byte_valid;
        rx.data = shift;
        rx.stop = events.clk_rise && events.dq && (sub_count == 4'(SUB_BITS - 1))
            && (bit_count == 3'd1);
        rx.timeout = timeout;
    end

endmodule

`default_nettype wire

// File: joybus/joybus_tx.sv
`default_nettype none

module joybus_tx (
    input  logic                   clk,
    input  logic                   reset,
    input  joybus_pkg::si_events_t events,
    input  joybus_pkg::tx_req_t    req,
    output logic                   busy,
    output logic                   line_low
);
    import joybus_pkg::*;

    logic [$clog2(SUB_BITS)-1:0] sub_count;
    logic [2:0]                  bit_count;
    logic [7:0]                  shift;

    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= 1'b0;
            line_low <= 1'b0;
            sub_count <= '0;
            bit_count <= '0;
        end else if (busy) begin
            if (events.clk_fall) begin
                sub_count <= sub_count + 1'b1;
                if (&sub_count) begin
                    bit_count <= bit_count + 3'd1;
                    shift <= {shift[6:0], 1'b0};
                    if (&bit_count) begin
                        busy <= 1'b0;
                    end
                end
                // Low for the first part of each bit period
                if (shift[7]) begin
                    line_low <= (sub_count < TX_ONE_LOW);
                end else begin
                    line_low <= (sub_count < TX_ZERO_LOW);
                end
            end
        end else if (req.byte_req) begin
            busy <= 1'b1;
            sub_count <= '0;
            bit_count <= '0;
            shift <= req.data;
        end else if (req.stop_req) begin
            // Stop is the last bit of a byte holding a single 1
            busy <= 1'b1;
            sub_count <= '0;
            bit_count <= 3'd7;
            shift <= 8'h80;
        end
    end

endmodule

`default_nettype wire

// File: src/si_cmd_ctrl.sv
`default_nettype none

module si_cmd_ctrl (
    input  logic                                 clk,
    input  logic                                 reset,
    input  joybus_pkg::rx_byte_t                 rx,
    input  logic                                 tx_busy,
    input  logic                                 eeprom_enabled,
    input  logic                                 eeprom_16k_mode,
    input  logic [7:0]                           eeprom_rdata,
    output joybus_pkg::tx_req_t                  tx,
    output logic                                 eeprom_write,
    output logic [joybus_pkg::EEPROM_ADDR_W-1:0] eeprom_address,
    output logic [7:0]                           eeprom_wdata,
    output logic                                 rtc_write,
    output logic [1:0]                           rtc_block,
    output logic [3:0]                           rtc_index,
    output logic [7:0]                           rtc_wdata,
    input  joybus_pkg::rtc_time_t                rtc_time,
    input  logic                                 rtc_time_wp,
    input  logic                                 rtc_backup_wp,
    input  logic [1:0]                           rtc_stopped
);
    import joybus_pkg::*;

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_DATA,
        RX_IGNORE
    } rx_state_e;

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_DATA,
        TX_STOP
    } tx_state_e;

    rx_state_e  rx_state;
    tx_state_e  tx_state;
    cmd_e       cmd;
    logic [3:0] rx_byte_count;
    logic [3:0] tx_byte_count;
    logic [3:0] tx_length;
    logic       tx_start;
    logic       byte_req;
    logic       stop_req;
    logic       tx_accept;
    logic       rx_data_valid;
    logic [7:0] tx_data;
    logic [7:0] status_byte;
    logic [7:0] address;
    logic [2:0] sub_address;

    always_comb begin
        rx_data_valid = rx.valid && (rx_state == RX_DATA);
        tx_accept = byte_req && !tx_busy;
        status_byte = {(|rtc_stopped), 7'd0};
    end

    always_ff @(posedge clk) begin
        tx_start <= 1'b0;
        if (rx.valid) begin
            rx_byte_count <= rx_byte_count + 4'd1;
        end
        if (reset || rx.timeout) begin
            rx_state <= RX_IDLE;
        end else begin
            case (rx_state)
                RX_IDLE: begin
                    if (rx.valid) begin
                        cmd <= cmd_e'(rx.data);
                        rx_byte_count <= '0;
                        rx_state <= RX_IGNORE;
                        case (rx.data)
                            CMD_EEPROM_STATUS, CMD_EEPROM_READ, CMD_EEPROM_WRITE: begin
                                if (eeprom_enabled) begin
                                    rx_state <= RX_DATA;
                                end
                            end
                            CMD_RTC_STATUS, CMD_RTC_READ, CMD_RTC_WRITE: begin
                                rx_state <= RX_DATA;
                            end
                            default: ;
                        endcase
                    end
                end
                RX_DATA: begin
                    if (rx.stop) begin
                        tx_start <= 1'b1;
                        rx_state <= RX_IGNORE;
                    end
                end
                default: begin
                    if (rx.stop) begin
                        rx_state <= RX_IDLE;
                    end
                end
            endcase
        end
    end

    // Byte offered every cycle, counted only when the encoder takes it
    always_ff @(posedge clk) begin
        if (tx_accept) begin
            tx_byte_count <= tx_byte_count + 4'd1;
        end
        if (reset) begin
            tx_state <= TX_IDLE;
            byte_req <= 1'b0;
            stop_req <= 1'b0;
        end else begin
            byte_req <= 1'b0;
            stop_req <= 1'b0;
            case (tx_state)
                TX_IDLE: begin
                    if (tx_start) begin
                        tx_byte_count <= '0;
                        tx_state <= TX_DATA;
                    end
                end
                TX_DATA: begin
                    byte_req <= 1'b1;
                    if (tx_accept && (tx_byte_count == tx_length)) begin
                        tx_state <= TX_STOP;
                    end
                end
                TX_STOP: begin
                    stop_req <= 1'b1;
                    if (stop_req && !tx_busy) begin
                        tx_state <= TX_IDLE;
                    end
                end
                default: tx_state <= TX_IDLE;
            endcase
        end
    end

    // First data byte is the block, sub-address walks from there
    always_ff @(posedge clk) begin
        if (rx_data_valid || tx_accept) begin
            sub_address <= sub_address + 3'd1;
        end
        if (rx_data_valid && (rx_byte_count == 4'd0)) begin
            address <= rx.data;
            sub_address <= '0;
        end
    end

    always_comb begin
        eeprom_write = rx_data_valid && (cmd == CMD_EEPROM_WRITE) && (rx_byte_count != 4'd0);
        eeprom_address = {address, sub_address};
        eeprom_wdata = rx.data;
        rtc_write = rx_data_valid && (cmd == CMD_RTC_WRITE) && (rx_byte_count != 4'd0);
        rtc_block = address[1:0];
        rtc_index = rx_byte_count;
        rtc_wdata = rx.data;
    end

    // Reply byte selection
    always_comb begin
        tx_length = 4'd0;
        tx_data = 8'h00;
        case (cmd)
            CMD_EEPROM_STATUS: begin
                tx_length = 4'd2;
                if (tx_byte_count == 4'd1) begin
                    tx_data = {1'b1, eeprom_16k_mode, 6'd0};
                end
            end
            CMD_EEPROM_READ: begin
                tx_length = 4'd7;
                tx_data = eeprom_rdata;
            end
            CMD_RTC_STATUS: begin
                tx_length = 4'd2;
                if (tx_byte_count == 4'd1) begin
                    tx_data = 8'h10;
                end else if (tx_byte_count == 4'd2) begin
                    tx_data = status_byte;
                end
            end
            CMD_RTC_READ: begin
                tx_length = 4'd8;
                if (tx_byte_count == 4'd8) begin
                    tx_data = status_byte;
                end else if (address[1:0] == 2'd0) begin
                    case (tx_byte_count)
                        4'd0: tx_data = {6'd0, rtc_time_wp, rtc_backup_wp};
                        4'd1: tx_data = {5'd0, rtc_stopped, 1'b0};
                        default: ;
                    endcase
                end else if (address[1:0] == 2'd2) begin
                    case (tx_byte_count)
                        4'd0: tx_data = {1'b0, rtc_time.seconds};
                        4'd1: tx_data = {1'b0, rtc_time.minutes};
                        // 24 hour flag in bit 7
                        4'd2: tx_data = {2'b10, rtc_time.hours};
                        4'd3: tx_data = {2'd0, rtc_time.day};
                        4'd4: tx_data = {5'd0, rtc_time.weekday};
                        4'd5: tx_data = {3'd0, rtc_time.month};
                        4'd6: tx_data = rtc_time.year;
                        4'd7: tx_data = 8'h01;
                        default: ;
                    endcase
                end
            end
            CMD_RTC_WRITE: begin
                tx_data = status_byte;
            end
            default: ;
        endcase
    end

    always_comb begin
        tx.byte_req = byte_req;
        tx.stop_req = stop_req;
        tx.data = tx_data;
    end

endmodule

`default_nettype wire

// File: src/rtc_regs.sv
`default_nettype none

module rtc_regs (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  write,
    input  logic [1:0]            block,
    input  logic [3:0]            index,
    input  logic [7:0]            wdata,
    output joybus_pkg::rtc_time_t rtc_time,
    output logic                  time_wp,
    output logic                  backup_wp,
    output logic [1:0]            stopped
);

    // Control block
    always_ff @(posedge clk) begin
        if (reset) begin
            time_wp <= 1'b1;
            backup_wp <= 1'b1;
            stopped <= 2'b00;
        end else if (write && (block == 2'd0)) begin
            case (index)
                4'd1: {time_wp, backup_wp} <= wdata[1:0];
                4'd2: stopped <= wdata[2:1];
                default: ;
            endcase
        end
    end

    // Time fields change only while the time protect bit is clear
    always_ff @(posedge clk) begin
        if (write && (block == 2'd2) && !time_wp) begin
            case (index)
                4'd1: rtc_time.seconds <= wdata[6:0];
                4'd2: rtc_time.minutes <= wdata[6:0];
                4'd3: rtc_time.hours <= wdata[5:0];
                4'd4: rtc_time.day <= wdata[5:0];
                4'd5: rtc_time.weekday <= wdata[2:0];
                4'd6: rtc_time.month <= wdata[4:0];
                4'd7: rtc_time.year <= wdata;
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: src/eeprom_mem.sv
`default_nettype none

module eeprom_mem (
    input  logic                                 clk,
    input  logic                                 write,
    input  logic [joybus_pkg::EEPROM_ADDR_W-1:0] address,
    input  logic [7:0]                           wdata,
    output logic [7:0]                           rdata
);
    import joybus_pkg::*;

    logic [7:0] mem [2**EEPROM_ADDR_W];

    always_ff @(posedge clk) begin
        if (write) begin
            mem[address] <= wdata;
        end
    end

    assign rdata = mem[address];

endmodule

`default_nettype wire

// File: src/si_top.sv
`default_nettype none

module si_top (
    input  logic clk,
    input  logic reset,
    input  logic host_reset,
    input  logic host_clk,
    input  logic dq_in,
    input  logic eeprom_enabled,
    input  logic eeprom_16k_mode,
    output logic dq_oe
);
    import joybus_pkg::*;

    si_events_t                events;
    rx_byte_t                  rx;
    tx_req_t                   tx;
    rtc_time_t                 rtc_time;
    logic                      tx_busy;
    logic                      line_low;
    logic                      eeprom_write;
    logic [EEPROM_ADDR_W-1:0]  eeprom_address;
    logic [7:0]                eeprom_wdata;
    logic [7:0]                eeprom_rdata;
    logic                      rtc_write;
    logic [1:0]                rtc_block;
    logic [3:0]                rtc_index;
    logic [7:0]                rtc_wdata;
    logic                      rtc_time_wp;
    logic                      rtc_backup_wp;
    logic [1:0]                rtc_stopped;

    si_line_sync u_sync (
        .clk        (clk),
        .reset      (reset),
        .host_reset (host_reset),
        .host_clk   (host_clk),
        .dq_in      (dq_in),
        .line_low   (line_low),
        .events     (events),
        .dq_oe      (dq_oe)
    );

    joybus_rx u_rx (
        .clk    (clk),
        .reset  (reset),
        .events (events),
        .rx     (rx)
    );

    joybus_tx u_tx (
        .clk      (clk),
        .reset    (reset),
        .events   (events),
        .req      (tx),
        .busy     (tx_busy),
        .line_low (line_low)
    );

    si_cmd_ctrl u_ctrl (
        .clk             (clk),
        .reset           (reset),
        .rx              (rx),
        .tx_busy         (tx_busy),
        .eeprom_enabled  (eeprom_enabled),
        .eeprom_16k_mode (eeprom_16k_mode),
        .eeprom_rdata    (eeprom_rdata),
        .tx              (tx),
        .eeprom_write    (eeprom_write),
        .eeprom_address  (eeprom_address),
        .eeprom_wdata    (eeprom_wdata),
        .rtc_write       (rtc_write),
        .rtc_block       (rtc_block),
        .rtc_index       (rtc_index),
        .rtc_wdata       (rtc_wdata),
        .rtc_time        (rtc_time),
        .rtc_time_wp     (rtc_time_wp),
        .rtc_backup_wp   (rtc_backup_wp),
        .rtc_stopped     (rtc_stopped)
    );

    rtc_regs u_rtc (
        .clk       (clk),
        .reset     (reset),
        .write     (rtc_write),
        .block     (rtc_block),
        .index     (rtc_index),
        .wdata     (rtc_wdata),
        .rtc_time  (rtc_time),
        .time_wp   (rtc_time_wp),
        .backup_wp (rtc_backup_wp),
        .stopped   (rtc_stopped)
    );

    eeprom_mem u_eeprom (
        .clk     (clk),
        .write   (eeprom_write),
        .address (eeprom_address),
        .wdata   (eeprom_wdata),
        .rdata   (eeprom_rdata)
    );

endmodule

`default_nettype wire

// File: verif/si_props.sv
`default_nettype none

module si_props (
    input logic       clk,
    input logic       reset,
    input logic       dq_oe,
    input logic       line_low,
    input logic       eeprom_write,
    input logic       eeprom_enabled,
    input logic [1:0] rx_state
);
    timeunit 1ns;
    timeprecision 100ps;

    // Receive FSM data state encoding
    localparam logic [1:0] RX_DATA = 2'd1;

    assert property (@(posedge clk) reset |=> !dq_oe)
        else $error("dq_oe high in the cycle after reset");

    assert property (@(posedge clk) disable iff (reset) !(eeprom_write && !eeprom_enabled))
        else $error("EEPROM write strobe while EEPROM disabled");

    // Host owns the line while a command is being received
    assert property (@(posedge clk) disable iff (reset) !(line_low && rx_state == RX_DATA))
        else $error("Transmitter drives the line during command receive");

endmodule

bind si_top si_props props (
    .clk            (clk),
    .reset          (reset),
    .dq_oe          (dq_oe),
    .line_low       (line_low),
    .eeprom_write   (eeprom_write),
    .eeprom_enabled (eeprom_enabled),
    .rx_state       (u_ctrl.rx_state)
);

`default_nettype wire

// File: verif/si_tb.sv
`default_nettype none

module si_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import joybus_pkg::*;

    localparam int TEST_WORDS = 1024;
    // Idle host clock rises before a reply, after a reply, and when none is expected
    localparam int REPLY_START_IDLE = 12;
    localparam int REPLY_END_IDLE = 20;
    localparam int NO_REPLY_IDLE = 48;

    logic clk;
    logic reset;
    logic host_reset;
    logic host_clk;
    logic host_low;
    logic dq_in;
    logic eeprom_enabled;
    logic eeprom_16k_mode;
    logic dq_oe;

    logic [7:0] test_mem [TEST_WORDS];
    logic       reply_bits [$];
    int         host_div;
    int         cycles;
    int         cycle_limit;
    int         errors;
    int         checks;

    si_top DUT (
        .clk             (clk),
        .reset           (reset),
        .host_reset      (host_reset),
        .host_clk        (host_clk),
        .dq_in           (dq_in),
        .eeprom_enabled  (eeprom_enabled),
        .eeprom_16k_mode (eeprom_16k_mode),
        .dq_oe           (dq_oe)
    );

    // Open-drain line, high unless someone pulls it low
    always @(negedge clk) begin
        dq_in <= !(host_low || dq_oe);
    end

    always #2 clk = ~clk;

    // Host clock toggles every 8 system clocks
    always @(negedge clk) begin
        if (host_div == 7) begin
            host_div <= 0;
            host_clk <= ~host_clk;
        end else begin
            host_div <= host_div + 1;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > cycle_limit) begin
            $display("Timeout: no end of the tests within %0d cycles", cycle_limit);
            $display("Checks failed");
            $finish;
        end
    end

    // Stop bit and line idle are counted as one byte each per transaction
    task automatic compute_limit();
        int pos;
        int total;
        int n_cmd;
        int n_rep;
        pos = 0;
        total = 0;
        while (pos < TEST_WORDS - 3 && test_mem[pos] !== 8'hff) begin
            n_cmd = test_mem[pos + 2];
            n_rep = test_mem[pos + 3 + n_cmd];
            total = total + n_cmd + n_rep + 2;
            pos = pos + 4 + n_cmd + n_rep;
        end
        cycle_limit = total * 64 * 16 + 2000;
    endtask

    // Called at a host clock fall, returns at the fall that starts the next bit
    task automatic send_bit(input logic value);
        int low_width;
        low_width = value ? TX_ONE_LOW : TX_ZERO_LOW;
        host_low = 1'b1;
        repeat (low_width) @(negedge host_clk);
        host_low = 1'b0;
        repeat (SUB_BITS - low_width) @(negedge host_clk);
    endtask

    task automatic send_byte(input logic [7:0] value);
        for (int i = 7; i >= 0; i--) begin
            send_bit(value[i]);
        end
    endtask

    task automatic send_stop();
        host_low = 1'b1;
        repeat (TX_ONE_LOW) @(negedge host_clk);
        host_low = 1'b0;
    endtask

    // Low pulse width in host clock rises decides each bit
    task automatic receive_reply(input logic expect_reply);
        int low_count;
        int high_count;
        int idle_limit;
        reply_bits.delete();
        low_count = 0;
        high_count = 0;
        idle_limit = expect_reply ? REPLY_START_IDLE : NO_REPLY_IDLE;
        while (high_count < idle_limit) begin
            @(posedge host_clk);
            if (dq_oe || host_low) begin
                low_count++;
                high_count = 0;
            end else begin
                if (low_count > 0) begin
                    reply_bits.push_back(low_count < ONE_LOW_MAX);
                    low_count = 0;
                end
                high_count++;
            end
            if (reply_bits.size() > 0) begin
                idle_limit = REPLY_END_IDLE;
            end
        end
    endtask

    task automatic check_reply(input int first, input int count);
        logic [7:0] got;
        int         n_bits;
        n_bits = reply_bits.size();
        checks++;
        if (count == 0) begin
            assert (n_bits == 0) else begin
                errors++;
                $display("Device answered with %0d bits to a command that needs no reply",
                    n_bits);
            end
        end else if (n_bits == 0) begin
            errors++;
            $display("No reply from the device at %0t, expected %0d bytes", $time, count);
        end else begin
            assert (n_bits == 8 * count + 1) else begin
                errors++;
                $display("Reply at %0t had %0d bits, expected %0d bytes and a stop bit",
                    $time, n_bits, count);
            end
            for (int b = 0; b < count && 8 * b + 7 < n_bits; b++) begin
                got = '0;
                for (int i = 0; i < 8; i++) begin
                    got = {got[6:0], reply_bits[8 * b + i]};
                end
                checks++;
                assert (got == test_mem[first + b]) else begin
                    errors++;
                    $display("CHECK FAILED t=%0t dq_oe reply byte %0d: got %02h expected %02h",
                        $time, b, got, test_mem[first + b]);
                end
            end
            if (n_bits == 8 * count + 1) begin
                checks++;
                assert (reply_bits[n_bits - 1] == 1'b1) else begin
                    errors++;
                    $display("Device stop bit at %0t decoded as 0", $time);
                end
            end
        end
    endtask

    initial begin
        int pos;
        int n_cmd;
        int n_rep;
        clk = 1'b0;
        host_clk = 1'b0;
        host_div = 0;
        cycles = 0;
        cycle_limit = 32'h7fff_ffff;
        errors = 0;
        checks = 0;
        reset = 1'b1;
        host_reset = 1'b0;
        host_low = 1'b0;
        dq_in = 1'b1;
        eeprom_enabled = 1'b0;
        eeprom_16k_mode = 1'b0;
        $readmemh("verif/si_tests.txt", test_mem);
        compute_limit();

        repeat (16) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        host_reset = 1'b1;
        repeat (4) @(negedge host_clk);

        pos = 0;
        while (pos < TEST_WORDS - 3 && test_mem[pos] !== 8'hff) begin
            n_cmd = test_mem[pos + 2];
            n_rep = test_mem[pos + 3 + n_cmd];
            @(negedge host_clk);
            eeprom_enabled = test_mem[pos][0];
            eeprom_16k_mode = test_mem[pos + 1][0];
            for (int i = 0; i < n_cmd; i++) begin
                send_byte(test_mem[pos + 3 + i]);
            end
            send_stop();
            receive_reply(n_rep != 0);
            check_reply(pos + 4 + n_cmd, n_rep);
            pos = pos + 4 + n_cmd + n_rep;
        end

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verif/si_tests.txt
// enable mode n_cmd cmd_bytes n_reply reply_bytes, all hex
// a line holding ff ends the list
01 00 01 00 03 00 80 00
01 01 01 00 03 00 c0 00
01 00 0a 05 03 11 22 33 44 55 66 77 88 01 00
01 00 0a 05 05 a1 b2 c3 d4 e5 f6 07 18 01 00
01 00 02 04 03 08 11 22 33 44 55 66 77 88
01 00 02 04 05 08 a1 b2 c3 d4 e5 f6 07 18
00 00 01 00 00
00 00 0a 05 03 ff ee dd cc bb aa 99 00 00
00 00 02 04 03 00
00 00 01 06 03 00 10 00
01 00 02 04 03 08 11 22 33 44 55 66 77 88
01 00 02 07 00 09 03 00 00 00 00 00 00 00 00
01 00 0a 08 00 00 00 00 00 00 00 00 00 01 00
01 00 0a 08 02 35 42 13 21 04 09 25 00 01 00
01 00 02 07 02 09 35 42 93 21 04 09 25 01 00
01 00 02 07 00 09 00 00 00 00 00 00 00 00 00
01 00 0a 08 00 02 00 00 00 00 00 00 00 01 00
01 00 0a 08 02 11 12 05 06 01 02 30 00 01 00
01 00 02 07 02 09 35 42 93 21 04 09 25 01 00
01 00 02 07 00 09 02 00 00 00 00 00 00 00 00
01 00 0a 08 00 02 06 00 00 00 00 00 00 01 80
01 00 01 06 03 00 10 80
01 00 02 07 00 09 02 06 00 00 00 00 00 00 80
ff

// File: verilog.f
common/joybus_pkg.sv
joybus/si_line_sync.sv
joybus/joybus_rx.sv
joybus/joybus_tx.sv
src/si_cmd_ctrl.sv
src/rtc_regs.sv
src/eeprom_mem.sv
src/si_top.sv
verif/si_props.sv
verif/si_tb.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module si_tb -f verilog.f -o si_sim
./obj_dir/si_sim > sim.log 2>&1 || true
cat sim.log
if grep -q "Checks failed" sim.log; then
    exit 1
fi
grep -q "All checks passed" sim.log
